/* run.sh */
#!/bin/sh
# Build and run the CDC FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cdc_fifo_tb \
  -f tb.f \
  -o cdc_fifo_sim

./obj_dir/cdc_fifo_sim

/* sim/cdc_fifo_props.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_props
  import cdc_fifo_pkg::*;
(
  input logic  push_clk,
  input logic  pop_clk,
  input logic  arst_n,
  input logic  push_valid,
  input logic  push_credit,
  input logic  push_receiver_in_reset,
  input logic  pop_valid,
  input logic  pop_ready,
  input data_t pop_data
);

  // Running totals of credits handed out and words pushed
  int unsigned granted;
  int unsigned pushed;

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      granted <= '0;
      pushed  <= '0;
    end else begin
      if (push_credit) begin
        granted <= granted + 32'd1;
      end
      if (push_valid) begin
        pushed <= pushed + 32'd1;
      end
    end
  end

  // P1 each push spends a credit granted in an earlier cycle
  p1_push_within_credit: assert property (
    @(posedge push_clk) disable iff (!arst_n) push_valid |-> (pushed < granted)
  ) else $error("push_valid without a held credit");

  // P2
  p2_no_credit_in_reset: assert property (
    @(posedge push_clk) disable iff (!arst_n) push_receiver_in_reset |-> !push_credit
  ) else $error("push_credit while the receiver is in reset");

  // P3 a stalled word stays put until it is taken
  p3_pop_data_held: assert property (
    @(posedge pop_clk) disable iff (!arst_n)
      (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_data))
  ) else $error("pop_data changed under back-pressure");

endmodule

`default_nettype wire

/* sim/cdc_fifo_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
;

  // One row per traffic phase
  // expect_full holds pop_ready low until the FIFO has filled
  typedef struct packed {
    int         pushes;
    logic [3:0] ready_pattern;
    int         stall_len;
    logic       expect_full;
  } phase_t;

  localparam int NumPhases = 4;

  logic  push_clk;
  logic  pop_clk;
  logic  arst_n;
  logic  push_sender_in_reset;
  logic  push_receiver_in_reset;
  logic  push_credit_stall;
  logic  push_credit;
  logic  push_valid;
  data_t push_data;
  logic  push_full;
  cnt_t  push_slots;
  logic  pop_ready;
  logic  pop_valid;
  data_t pop_data;
  logic  pop_empty;
  cnt_t  pop_items;

  integer seed;
  // Credits seen on push_credit and credits spent on pushes
  int     credits_got;
  int     credits_used;
  int     sent;
  data_t  sb [$];

  phase_t phases [NumPhases] = '{
    '{12, 4'b1111, 0, 1'b0},
    '{8, 4'b1101, 0, 1'b1},
    '{10, 4'b1010, 6, 1'b0},
    '{16, 4'b0111, 3, 1'b0}
  };

  cdc_fifo_top #(
    .NumSyncStages (3),
    .RamReadLatency(1)
  ) cdc_fifo_top_inst (
    .push_clk              (push_clk),
    .pop_clk               (pop_clk),
    .arst_n                (arst_n),
    .push_sender_in_reset  (push_sender_in_reset),
    .push_receiver_in_reset(push_receiver_in_reset),
    .push_credit_stall     (push_credit_stall),
    .push_credit           (push_credit),
    .push_valid            (push_valid),
    .push_data             (push_data),
    .push_full             (push_full),
    .push_slots            (push_slots),
    .pop_ready             (pop_ready),
    .pop_valid             (pop_valid),
    .pop_data              (pop_data),
    .pop_empty             (pop_empty),
    .pop_items             (pop_items)
  );

  bind cdc_fifo_top cdc_fifo_props props_inst (
    .push_clk              (push_clk),
    .pop_clk               (pop_clk),
    .arst_n                (arst_n),
    .push_valid            (push_valid),
    .push_credit           (push_credit),
    .push_receiver_in_reset(push_receiver_in_reset),
    .pop_valid             (pop_valid),
    .pop_ready             (pop_ready),
    .pop_data              (pop_data)
  );

  initial begin
    push_clk = 1'b0;
    forever #4 push_clk = ~push_clk;
  end

  initial begin
    pop_clk = 1'b0;
    forever #6 pop_clk = ~pop_clk;
  end

  // ------------------------------
  // Error handling and compares
  // ------------------------------

  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_timeout(string what);
    $display("Timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_data(data_t actual, data_t expected, string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_count(cnt_t actual, cnt_t expected, string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      stop_run();
    end
  endtask

  task automatic check_flag(logic actual, logic expected, string what);
    if (actual !== expected) begin
      $display("FAIL %0t: %s, got %b, expected %b", $time, what, actual, expected);
      stop_run();
    end
  endtask

  // Outputs of an empty FIFO that has granted nothing yet
  task automatic check_idle_outputs();
    check_flag(push_credit, 1'b0, "push_credit while idle");
    check_flag(pop_valid, 1'b0, "pop_valid while idle");
    check_flag(push_full, 1'b0, "push_full while idle");
    check_flag(pop_empty, 1'b1, "pop_empty while idle");
  endtask

  // ------------------------------
  // Credit monitor
  // ------------------------------

  // Sampled mid-cycle, a credit seen here can be spent from the next push cycle
  always @(negedge push_clk) begin
    if (arst_n && push_credit) begin
      if (push_credit_stall) begin
        check_flag(push_credit, 1'b0, "credit pulse while push_credit_stall is high");
      end
      credits_got = credits_got + 1;
      check_flag(credits_got - credits_used <= DEPTH, 1'b1, "credits held beyond DEPTH");
    end
  end

  // ------------------------------
  // Traffic processes
  // ------------------------------

  // The sender pushes only while it holds a credit
  task automatic run_sender(int count);
    int guard;
    guard = 0;
    while (sent < count) begin
      @(posedge push_clk);
      #1;
      if (credits_got - credits_used > 0) begin
        push_valid = 1'b1;
        push_data  = data_t'($random(seed));
        sb.push_back(push_data);
        credits_used = credits_used + 1;
        sent = sent + 1;
      end else begin
        push_valid = 1'b0;
      end
      guard++;
      if (guard > 600) begin
        report_timeout("a credit to push the next word");
      end
    end
    @(posedge push_clk);
    #1;
    push_valid = 1'b0;
  endtask

  task automatic run_popper(phase_t ph);
    int         guard;
    int         popped;
    logic [1:0] duty_idx;
    guard    = 0;
    popped   = 0;
    duty_idx = 2'd0;
    if (ph.expect_full) begin
      // Nothing leaves, so the head word must sit still at pop_data
      while (pop_items != cnt_t'(DEPTH)) begin
        @(negedge pop_clk);
        if (pop_valid) begin
          check_flag(sb.size() != 0, 1'b1, "pop_valid with no word pushed");
          check_data(pop_data, sb[0], "word held under back-pressure");
        end
        guard++;
        if (guard > 400) begin
          report_timeout("pop_items to reach DEPTH");
        end
      end
      @(negedge push_clk);
      check_flag(push_full, 1'b1, "push_full with DEPTH words stored");
      check_count(push_slots, cnt_t'(0), "push_slots with DEPTH words stored");
      guard = 0;
    end
    while (popped < ph.pushes) begin
      @(posedge pop_clk);
      #1;
      pop_ready = ph.ready_pattern[duty_idx];
      duty_idx  = duty_idx + 2'd1;
      @(negedge pop_clk);
      // In-order delivery means pop_data always shows the oldest word
      if (pop_valid) begin
        check_flag(sb.size() != 0, 1'b1, "pop_valid with no word pushed");
        check_data(pop_data, sb[0], "pop_data in push order");
        if (pop_ready) begin
          void'(sb.pop_front());
          popped++;
        end
      end
      guard++;
      if (guard > 1000) begin
        report_timeout("the next pop handshake");
      end
    end
    @(posedge pop_clk);
    #1;
    pop_ready = 1'b0;
  endtask

  // The stall starts after the first pop so that returned slots pile up as owed credits
  task automatic run_stall(int len);
    int guard;
    guard = 0;
    if (len > 0) begin
      while (sent - sb.size() < 1) begin
        @(posedge push_clk);
        guard++;
        if (guard > 600) begin
          report_timeout("the first pop before the credit stall");
        end
      end
      @(posedge push_clk);
      #1;
      push_credit_stall = 1'b1;
      repeat (len) @(posedge push_clk);
      #1;
      push_credit_stall = 1'b0;
    end
  endtask

  // All slots freed means the sender holds exactly DEPTH credits again
  task automatic wait_credits_home();
    int guard;
    guard = 0;
    while (credits_got - credits_used != DEPTH) begin
      @(posedge push_clk);
      guard++;
      if (guard > 300) begin
        report_timeout("all credits to return");
      end
    end
    // A quiet window catches any credit beyond DEPTH
    repeat (20) @(posedge push_clk);
    // With every credit home the push side sees all slots free again
    @(negedge push_clk);
    check_count(push_slots, cnt_t'(DEPTH), "push_slots with all credits home");
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    seed                 = 32'he7b0;
    credits_got          = 0;
    credits_used         = 0;
    sent                 = 0;
    arst_n               = 1'b0;
    push_sender_in_reset = 1'b1;
    push_credit_stall    = 1'b0;
    push_valid           = 1'b0;
    push_data            = '0;
    pop_ready            = 1'b0;

    repeat (4) begin
      @(negedge push_clk);
      check_idle_outputs();
    end
    @(posedge push_clk);
    #1;
    arst_n = 1'b1;

    // The sender is still in reset, so the FIFO must hold back all credit
    repeat (5) begin
      @(negedge push_clk);
      check_idle_outputs();
      check_flag(push_receiver_in_reset, 1'b1, "receiver in reset with sender in reset");
    end
    @(posedge push_clk);
    #1;
    push_sender_in_reset = 1'b0;
    @(negedge push_clk);
    check_flag(push_credit, 1'b0, "credit one cycle after sender release");
    @(negedge push_clk);
    check_flag(push_credit, 1'b1, "first credit two cycles after sender release");
    check_flag(push_receiver_in_reset, 1'b0, "receiver out of reset");
    wait_credits_home();

    for (int p = 0; p < NumPhases; p++) begin
      sent = 0;
      fork
        run_sender(phases[p].pushes);
        run_popper(phases[p]);
        run_stall(phases[p].stall_len);
      join
      wait_credits_home();
      @(negedge pop_clk);
      check_flag(pop_empty, 1'b1, "pop_empty after phase");
      check_flag(pop_valid, 1'b0, "pop_valid after phase");
      check_flag(sb.size() == 0, 1'b1, "all pushed words popped");
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/cdc_fifo_credit_counter.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_credit_counter
  import cdc_fifo_pkg::*;
(
  input  logic push_clk,
  input  logic arst_n,
  input  logic load_initial,
  input  cnt_t slots_freed,
  input  logic take_credit,
  output logic owed
);

  cnt_t count;
  cnt_t count_next;
  // One bit wider than a count so the sum cannot wrap before the clamp
  logic [CNT_W:0] credit_sum;

  // ------------------------------
  // Credit arithmetic
  // ------------------------------

  // Freed slots come in as a group while credits leave one per cycle
  assign credit_sum = {1'b0, count} + {1'b0, slots_freed} - (CNT_W + 1)'(take_credit);

  always_comb begin
    if (load_initial) begin
      // Every slot is free at start so the sender is owed all of them
      count_next = cnt_t'(DEPTH);
    end else if (credit_sum > (CNT_W + 1)'(DEPTH)) begin
      // More credit than slots can only follow a protocol error
      count_next = cnt_t'(DEPTH);
    end else begin
      count_next = credit_sum[CNT_W-1:0];
    end
  end

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  // The credit FSM only needs to know whether anything is left to give
  assign owed = (count != '0);

endmodule

`default_nettype wire

/* src/cdc_fifo_credit_fsm.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_credit_fsm
  import cdc_fifo_pkg::*;
(
  input  logic push_clk,
  input  logic arst_n,
  input  logic push_sender_in_reset,
  input  logic push_credit_stall,
  input  logic owed,
  output logic load_initial,
  output logic take_credit,
  output logic push_receiver_in_reset
);

  fsm_state_t state;
  fsm_state_t state_next;

  // ------------------------------
  // Next state
  // ------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // Wait here until the sender has left its own reset
      IN_RESET: begin
        if (!push_sender_in_reset) begin
          state_next = GRANT;
        end
      end
      // The initial grant is over once the counter has drained to zero
      GRANT: begin
        if (!owed) begin
          state_next = RUN;
        end
      end
      RUN: begin
        state_next = RUN;
      end
      default: begin
        state_next = IN_RESET;
      end
    endcase
    // A sender that drops back into reset restarts the handshake
    if (push_sender_in_reset) begin
      state_next = IN_RESET;
    end
  end

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IN_RESET;
    end else begin
      state <= state_next;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------

  // Reported straight from the state flop so the sender sees a clean level
  assign push_receiver_in_reset = (state == IN_RESET);

  // The counter takes DEPTH on the same edge that leaves IN_RESET
  assign load_initial = (state == IN_RESET) && !push_sender_in_reset;

  // One credit per cycle while any are owed and the sender accepts them
  // A stalled credit stays in the counter until the stall clears
  assign take_credit = (state != IN_RESET) && owed && !push_credit_stall;

endmodule

`default_nettype wire

/* src/cdc_fifo_pkg.sv */
`default_nettype none

package cdc_fifo_pkg;

  // ------------------------------
  // FIFO sizes
  // ------------------------------

  // Number of RAM entries, which must stay a power of two for pointer wrap
  localparam int DEPTH = 8;
  localparam int ADDR_W = 3;
  // One extra bit so a count can hold the value DEPTH
  localparam int CNT_W = 4;
  localparam int DATA_W = 16;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0] cnt_t;

  // ------------------------------
  // RAM access requests
  // ------------------------------

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    data_t             data;
  } ram_wr_t;

  typedef struct packed {
    logic              addr_valid;
    logic [ADDR_W-1:0] addr;
  } ram_rd_t;

  // States of the push-side credit handshake
  typedef enum logic [1:0] {
    IN_RESET,
    GRANT,
    RUN
  } fsm_state_t;

  // Binary to gray conversion for counts that cross clock domains
  function automatic cnt_t bin2gray(cnt_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray to binary conversion, folding from the top bit down
  function automatic cnt_t gray2bin(cnt_t gray);
    cnt_t bin;
    bin[CNT_W-1] = gray[CNT_W-1];
    for (int i = CNT_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

/* src/cdc_fifo_pop_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_pop_ctrl
  import cdc_fifo_pkg::*;
#(
  parameter int NumSyncStages  = 3,
  parameter int RamReadLatency = 1
) (
  input  logic    pop_clk,
  input  logic    arst_n,
  input  logic    pop_ready,
  input  cnt_t    push_count_gray,
  output cnt_t    pop_count_gray,
  output ram_rd_t ram_rd,
  input  logic    rd_data_valid,
  input  data_t   rd_data,
  output logic    pop_valid,
  output data_t   pop_data,
  output logic    pop_empty,
  output cnt_t    pop_items
);

  // The staging buffer holds one entry per cycle of read latency plus one
  localparam int StageDepth = RamReadLatency + 1;
  localparam int PtrW = (StageDepth > 1) ? $clog2(StageDepth) : 1;
  localparam int OccW = $clog2(StageDepth + 1);

  cnt_t [NumSyncStages-1:0] push_gray_sync;
  cnt_t push_bin;
  // Next RAM entry to read, and the count of items handed out
  cnt_t rd_count;
  cnt_t pop_count;
  cnt_t unread;
  logic issue;
  logic pop_fire;
  logic [OccW-1:0] inflight;
  logic [OccW-1:0] stage_count;
  logic [PtrW-1:0] stage_wr_ptr;
  logic [PtrW-1:0] stage_rd_ptr;
  data_t stage_mem [StageDepth];

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(StageDepth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  // ------------------------------
  // Push count from the push domain
  // ------------------------------

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      push_gray_sync <= '0;
    end else begin
      push_gray_sync[0] <= push_count_gray;
      for (int i = 1; i < NumSyncStages; i++) begin
        push_gray_sync[i] <= push_gray_sync[i-1];
      end
    end
  end

  assign push_bin = gray2bin(push_gray_sync[NumSyncStages-1]);

  // ------------------------------
  // RAM read issue
  // ------------------------------

  assign unread = push_bin - rd_count;

  // Every read in flight has a staging slot waiting for it
  assign issue = (unread != '0) &&
                 ((OccW + 1)'(inflight) + (OccW + 1)'(stage_count) < (OccW + 1)'(StageDepth));

  assign ram_rd.addr_valid = issue;
  assign ram_rd.addr       = rd_count[ADDR_W-1:0];

  // ------------------------------
  // Staging buffer and pop count
  // ------------------------------

  assign pop_valid = (stage_count != '0);
  assign pop_data  = stage_mem[stage_rd_ptr];
  assign pop_fire  = pop_valid && pop_ready;

  always_ff @(posedge pop_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_count       <= '0;
      pop_count      <= '0;
      pop_count_gray <= '0;
      inflight       <= '0;
      stage_count    <= '0;
      stage_wr_ptr   <= '0;
      stage_rd_ptr   <= '0;
    end else begin
      if (issue) begin
        rd_count <= rd_count + cnt_t'(1);
      end
      inflight    <= inflight + OccW'(issue) - OccW'(rd_data_valid);
      stage_count <= stage_count + OccW'(rd_data_valid) - OccW'(pop_fire);
      if (rd_data_valid) begin
        stage_wr_ptr <= next_ptr(stage_wr_ptr);
      end
      // The slot is only freed toward the push side once the word leaves
      if (pop_fire) begin
        stage_rd_ptr   <= next_ptr(stage_rd_ptr);
        pop_count      <= pop_count + cnt_t'(1);
        pop_count_gray <= bin2gray(pop_count + cnt_t'(1));
      end
    end
  end

  // Returned words go into the slot that their read reserved
  always_ff @(posedge pop_clk) begin
    if (rd_data_valid) begin
      stage_mem[stage_wr_ptr] <= rd_data;
    end
  end

  // Items still owed to the consumer, whether in the RAM or staged
  assign pop_items = push_bin - pop_count;
  assign pop_empty = (pop_items == '0);

endmodule

`default_nettype wire

/* src/cdc_fifo_push_ctrl.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_push_ctrl
  import cdc_fifo_pkg::*;
#(
  parameter int NumSyncStages = 3
) (
  input  logic    push_clk,
  input  logic    arst_n,
  input  logic    push_valid,
  input  data_t   push_data,
  input  cnt_t    pop_count_gray,
  output cnt_t    push_count_gray,
  output cnt_t    slots_freed,
  output ram_wr_t ram_wr,
  output logic    push_full,
  output cnt_t    push_slots
);

  // Binary write count, whose low bits address the RAM
  cnt_t wr_count;
  // Synchronizer chain for the gray pop count, index 0 samples first
  cnt_t [NumSyncStages-1:0] pop_gray_sync;
  cnt_t pop_bin;
  cnt_t pop_bin_q;
  cnt_t push_items;

  // ------------------------------
  // Write side
  // ------------------------------

  // A push goes to the RAM in the cycle it is presented
  assign ram_wr.valid = push_valid;
  assign ram_wr.addr  = wr_count[ADDR_W-1:0];
  assign ram_wr.data  = push_data;

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_count        <= '0;
      push_count_gray <= '0;
    end else begin
      if (push_valid) begin
        wr_count <= wr_count + cnt_t'(1);
      end
      // The gray copy trails the binary count by one cycle
      // so the RAM write has landed before the pop side can see it
      push_count_gray <= bin2gray(wr_count);
    end
  end

  // ------------------------------
  // Pop count from the pop domain
  // ------------------------------

  always_ff @(posedge push_clk or negedge arst_n) begin
    if (!arst_n) begin
      pop_gray_sync <= '0;
      pop_bin_q     <= '0;
    end else begin
      pop_gray_sync[0] <= pop_count_gray;
      for (int i = 1; i < NumSyncStages; i++) begin
        pop_gray_sync[i] <= pop_gray_sync[i-1];
      end
      pop_bin_q <= pop_bin;
    end
  end

  assign pop_bin = gray2bin(pop_gray_sync[NumSyncStages-1]);

  // Several pops may show up in one push cycle when the pop clock is faster
  assign slots_freed = pop_bin - pop_bin_q;

  // ------------------------------
  // Status
  // ------------------------------

  // Items counted here include pops that have not crossed over yet
  assign push_items = wr_count - pop_bin;
  assign push_slots = cnt_t'(DEPTH) - push_items;
  assign push_full  = (push_slots == '0);

endmodule

`default_nettype wire

/* src/cdc_fifo_ram.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_ram
  import cdc_fifo_pkg::*;
#(
  parameter int RamReadLatency = 1
) (
  input  logic    push_clk,
  input  logic    pop_clk,
  input  logic    arst_n,
  input  ram_wr_t ram_wr,
  input  ram_rd_t ram_rd,
  output logic    rd_data_valid,
  output data_t   rd_data
);

  data_t mem [DEPTH];

  // Writes happen in the push domain only
  always_ff @(posedge push_clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // ------------------------------
  // Read path in the pop domain
  // ------------------------------

  if (RamReadLatency == 0) begin : g_comb_read
    // The entry read here was made stable by the gray count handshake
    assign rd_data_valid = ram_rd.addr_valid;
    assign rd_data       = mem[ram_rd.addr];
  end else begin : g_flop_read
    logic [RamReadLatency-1:0] vld_q;
    data_t [RamReadLatency-1:0] data_q;

    always_ff @(posedge pop_clk or negedge arst_n) begin
      if (!arst_n) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= ram_rd.addr_valid;
        for (int i = 1; i < RamReadLatency; i++) begin
          vld_q[i] <= vld_q[i-1];
        end
      end
    end

    // Data follows its valid bit down the same number of stages
    always_ff @(posedge pop_clk) begin
      data_q[0] <= mem[ram_rd.addr];
      for (int i = 1; i < RamReadLatency; i++) begin
        data_q[i] <= data_q[i-1];
      end
    end

    assign rd_data_valid = vld_q[RamReadLatency-1];
    assign rd_data       = data_q[RamReadLatency-1];
  end

endmodule

`default_nettype wire

/* src/cdc_fifo_top.sv */
`default_nettype none
`timescale 1ns/100ps

module cdc_fifo_top
  import cdc_fifo_pkg::*;
#(
  parameter int NumSyncStages  = 3,
  parameter int RamReadLatency = 1
) (
  input  logic  push_clk,
  input  logic  pop_clk,
  input  logic  arst_n,
  // Credit/valid push interface
  input  logic  push_sender_in_reset,
  output logic  push_receiver_in_reset,
  input  logic  push_credit_stall,
  output logic  push_credit,
  input  logic  push_valid,
  input  data_t push_data,
  output logic  push_full,
  output cnt_t  push_slots,
  // Ready/valid pop interface
  input  logic  pop_ready,
  output logic  pop_valid,
  output data_t pop_data,
  output logic  pop_empty,
  output cnt_t  pop_items
);

  ram_wr_t ram_wr;
  ram_rd_t ram_rd;
  logic    rd_data_valid;
  data_t   rd_data;
  // Gray counts that cross between the two domains
  cnt_t    push_count_gray;
  cnt_t    pop_count_gray;
  cnt_t    slots_freed;
  logic    owed;
  logic    load_initial;

  // ------------------------------
  // Push domain
  // ------------------------------

  cdc_fifo_push_ctrl #(
    .NumSyncStages(NumSyncStages)
  ) push_ctrl_inst (
    .push_clk       (push_clk),
    .arst_n         (arst_n),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .pop_count_gray (pop_count_gray),
    .push_count_gray(push_count_gray),
    .slots_freed    (slots_freed),
    .ram_wr         (ram_wr),
    .push_full      (push_full),
    .push_slots     (push_slots)
  );

  cdc_fifo_credit_counter credit_counter_inst (
    .push_clk    (push_clk),
    .arst_n      (arst_n),
    .load_initial(load_initial),
    .slots_freed (slots_freed),
    .take_credit (push_credit),
    .owed        (owed)
  );

  // Each credit pulse to the sender also drains one from the counter
  cdc_fifo_credit_fsm credit_fsm_inst (
    .push_clk              (push_clk),
    .arst_n                (arst_n),
    .push_sender_in_reset  (push_sender_in_reset),
    .push_credit_stall     (push_credit_stall),
    .owed                  (owed),
    .load_initial          (load_initial),
    .take_credit           (push_credit),
    .push_receiver_in_reset(push_receiver_in_reset)
  );

  // ------------------------------
  // Storage and pop domain
  // ------------------------------

  cdc_fifo_ram #(
    .RamReadLatency(RamReadLatency)
  ) ram_inst (
    .push_clk     (push_clk),
    .pop_clk      (pop_clk),
    .arst_n       (arst_n),
    .ram_wr       (ram_wr),
    .ram_rd       (ram_rd),
    .rd_data_valid(rd_data_valid),
    .rd_data      (rd_data)
  );

  cdc_fifo_pop_ctrl #(
    .NumSyncStages (NumSyncStages),
    .RamReadLatency(RamReadLatency)
  ) pop_ctrl_inst (
    .pop_clk        (pop_clk),
    .arst_n         (arst_n),
    .pop_ready      (pop_ready),
    .push_count_gray(push_count_gray),
    .pop_count_gray (pop_count_gray),
    .ram_rd         (ram_rd),
    .rd_data_valid  (rd_data_valid),
    .rd_data        (rd_data),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .pop_empty      (pop_empty),
    .pop_items      (pop_items)
  );

endmodule

`default_nettype wire

/* tb.f */
src/cdc_fifo_pkg.sv
src/cdc_fifo_credit_fsm.sv
src/cdc_fifo_credit_counter.sv
src/cdc_fifo_push_ctrl.sv
src/cdc_fifo_pop_ctrl.sv
src/cdc_fifo_ram.sv
src/cdc_fifo_top.sv
sim/cdc_fifo_props.sv
sim/cdc_fifo_tb.sv
